// File: src.f
+incdir+common
common/core_pkg.sv
common/issue_if.sv
src/fetch.sv
src/regfile.sv
src/decode.sv
src/execute.sv
src/core.sv
verification/core_checker.sv
verification/core_tb.sv

// File: verification/core_tb.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core_tb import core_pkg::*; ();
	localparam int PROG_WORDS = 64;

	logic                   clk;
	logic                   reset;
	logic                   insn_req;
	logic [`CORE_XLEN-1:0]  insn_addr;
	logic                   insn_wait;
	logic [`CORE_XLEN-1:0]  insn_data;
	logic                   reg_write;
	logic [`CORE_REG_W-1:0] reg_num;
	logic [`CORE_XLEN-1:0]  reg_data;
	logic [3:0]             flags;

	integer      seed = 32'h0a0f_9ad6;
	logic [31:0] prog [PROG_WORDS];
	logic [31:0] m_regs [16];       // Architectural model state
	logic [3:0]  m_flags;           // N, Z, C, V
	logic [39:0] exp_q [$];         // rd, data, flags after the write
	int          err_value = 0;
	int          err_other = 0;
	int          writes = 0;

	core i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;      // 8 ns period
	end

	task automatic build_program();
		logic [3:0]  ops [10];
		logic [31:0] q;
		logic [31:0] c;
		insn_t       w;
		ops = '{`CORE_OP_AND, `CORE_OP_EOR, `CORE_OP_SUB, `CORE_OP_RSB, `CORE_OP_ADD,
			`CORE_OP_CMP, `CORE_OP_ORR, `CORE_OP_MOV, `CORE_OP_BIC, `CORE_OP_MVN};
		for (int i = 0; i < PROG_WORDS; i++) begin
			q = $random(seed);
			c = $random(seed);
			w = '0;
			if (i >= 8 && c[11:9] == 3'b000) begin
				w.br.cond   = c[0] ? `CORE_COND_AL : c[7:4];
				w.br.fmt    = 3'b101;
				w.br.offset = {22'h0, q[1:0]};  // Forward, skips one to four words
			end else begin
				w.dp.cond   = c[0] ? `CORE_COND_AL : c[7:4];
				w.dp.opcode = ops[q[3:0] % 10];
				w.dp.imm    = q[4];
				w.dp.s      = q[5] || w.dp.opcode == `CORE_OP_CMP;
				w.dp.rn     = q[7:6] == 2'b11 ? 4'hf : {1'b0, q[10:8]};
				w.dp.rd     = q[28] && q[12:11] == 2'b11 ? 4'hf : {1'b0, q[13:11]};  // r15 drops
				if (q[4]) begin
					w.dp.operand = q[27:16];
				end else begin
					w.dp.operand[3:0] = q[15:14] == 2'b11 ? 4'hf : {1'b0, q[18:16]};
					if (q[31:29] == 3'b111)
						w.dp.operand[11:4] = q[27:20];  // Shifted rm, retires as no-op
				end
			end
			if (i < 8) begin                           // Seed r0..r7 with immediates
				w.dp.cond    = `CORE_COND_AL;
				w.dp.fmt     = 2'b00;
				w.dp.imm     = 1'b1;
				w.dp.opcode  = `CORE_OP_MOV;
				w.dp.s       = 1'b0;
				w.dp.rd      = i[3:0];
				w.dp.operand = q[11:0];
			end
			prog[i] = w;
		end
	endtask

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		insn_t b;
		b = '0;
		b.br.cond   = `CORE_COND_AL;
		b.br.fmt    = 3'b101;
		b.br.offset = 24'hff_fffe;                     // Lands on itself
		fetch_word  = addr < 4 * PROG_WORDS ? prog[addr[7:2]] : b;
	endfunction

	// ARM table, odd codes invert the even ones
	function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
		logic base;
		case (cond[3:1])
			3'd0: base = f[2];                       // EQ
			3'd1: base = f[1];                       // CS
			3'd2: base = f[3];                       // MI
			3'd3: base = f[0];                       // VS
			3'd4: base = f[1] && !f[2];              // HI
			3'd5: base = f[3] == f[0];               // GE
			3'd6: base = !f[2] && f[3] == f[0];      // GT
			default: base = 1'b1;                    // AL, NV inverts to never
		endcase
		cond_holds = base ^ cond[0];
	endfunction

	function automatic logic [31:0] reg_val(input logic [3:0] n, input logic [31:0] pc);
		reg_val = n == 4'hf ? pc + 32'd8 : m_regs[n];
	endfunction

	// One instruction on the model, returns the next pc
	function automatic logic [31:0] model_step(input logic [31:0] pc, input insn_t w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [63:0] rr;
		logic [32:0] s33;
		logic        c;
		logic        v;
		logic        ok;
		ok = cond_holds(w.dp.cond, m_flags);
		model_step = pc + 32'd4;
		if (w.br.fmt == 3'b101 && !w.br.link) begin
			if (ok)
				model_step = pc + 32'd8 + {{6{w.br.offset[23]}}, w.br.offset, 2'b00};
		end else if (w.dp.fmt == 2'b00 && ok && (w.dp.imm || w.dp.operand[11:4] == 8'h00) &&
			w.dp.opcode inside {`CORE_OP_AND, `CORE_OP_EOR, `CORE_OP_SUB, `CORE_OP_RSB,
			`CORE_OP_ADD, `CORE_OP_CMP, `CORE_OP_ORR, `CORE_OP_MOV, `CORE_OP_BIC,
			`CORE_OP_MVN}) begin
			a = reg_val(w.dp.rn, pc);
			c = m_flags[1];                          // Shifter carry by default
			v = m_flags[0];
			if (w.dp.imm) begin
				rr = {2{24'h0, w.dp.operand[7:0]}} >> (2 * w.dp.operand[11:8]);
				b  = rr[31:0];                       // ror by twice the field
				if (w.dp.operand[11:8] != 4'h0)
					c = b[31];
			end else begin
				b = reg_val(w.dp.operand[3:0], pc);
			end
			case (w.dp.opcode)
				`CORE_OP_AND: r = a & b;
				`CORE_OP_EOR: r = a ^ b;
				`CORE_OP_ORR: r = a | b;
				`CORE_OP_MOV: r = b;
				`CORE_OP_BIC: r = a & ~b;
				`CORE_OP_MVN: r = ~b;
				`CORE_OP_ADD: begin
					s33 = {1'b0, a} + {1'b0, b};
					r   = s33[31:0];
					c   = s33[32];
					v   = a[31] == b[31] && r[31] != a[31];
				end
				`CORE_OP_RSB: begin
					r = b - a;
					c = b >= a;                      // No borrow
					v = b[31] != a[31] && r[31] != b[31];
				end
				default: begin                       // SUB, CMP
					r = a - b;
					c = a >= b;
					v = a[31] != b[31] && r[31] != a[31];
				end
			endcase
			if (w.dp.s)
				m_flags = {r[31], r == 32'h0, c, v};
			if (w.dp.opcode != `CORE_OP_CMP && w.dp.rd != 4'hf) begin
				m_regs[w.dp.rd] = r;
				exp_q.push_back({w.dp.rd, r, m_flags});
			end
		end
	endfunction

	// Memory model, one cycle of read latency
	initial begin
		logic        acc;
		logic [31:0] acc_addr;
		forever begin
			@(negedge clk);
			acc      = insn_req === 1'b1 && insn_wait === 1'b0;
			acc_addr = insn_addr;
			@(posedge clk);
			#1;
			insn_data <= acc ? fetch_word(acc_addr) : 32'h0;
			insn_wait <= ($random(seed) & 3) == 0;   // Busy a quarter of the time
		end
	end

	// Compare each retire against the queue head
	initial begin
		logic [39:0] e;
		forever begin
			@(negedge clk);
			if (reg_write === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected write to r%0d at %0t", reg_num, $time);
					err_other++;
				end else begin
					e = exp_q.pop_front();
					writes++;
					if (reg_num !== e[39:36]) begin
						$display("CHECK FAILED at %0t: reg_num got %0d expected %0d",
							$time, reg_num, e[39:36]);
						err_value++;
					end
					if (reg_data !== e[35:4]) begin
						$display("CHECK FAILED at %0t: reg_data got %h expected %h",
							$time, reg_data, e[35:4]);
						err_value++;
					end
					if (flags !== e[3:0]) begin
						$display("CHECK FAILED at %0t: flags got %b expected %b",
							$time, flags, e[3:0]);
						err_value++;
					end
				end
			end
		end
	end

	initial begin
		logic [31:0] pc;
		int          cycles;
		reset     = 1'b1;
		insn_wait = 1'b0;
		insn_data = 32'h0;
		build_program();
		for (int i = 0; i < 16; i++)
			m_regs[i] = 32'h0;
		m_flags = 4'h0;
		pc      = `CORE_RESET_PC;
		cycles  = 0;
		while (pc < 4 * PROG_WORDS && cycles < 1000) begin  // Branches only go forward
			pc = model_step(pc, prog[pc[7:2]]);
			cycles++;
		end
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 4000) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout waiting for %0d expected writes", exp_q.size());
			err_other++;
		end
		repeat (40) @(posedge clk);                 // Catch stray writes
		@(negedge clk);
		if (flags !== m_flags) begin
			$display("CHECK FAILED at %0t: flags got %b expected %b", $time, flags, m_flags);
			err_value++;
		end
		if (i_dut.i_checker.fail_count != 0) begin
			$display("Bound checker reported %0d assertion failures",
				i_dut.i_checker.fail_count);
			err_other += i_dut.i_checker.fail_count;
		end
		$display("Errors: %0d wrong values, %0d other, %0d writes checked",
			err_value, err_other, writes);
		if (err_value == 0 && err_other == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end
endmodule

// File: verification/core_checker.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   insn_req,
	input logic                   insn_wait,
	input logic [`CORE_XLEN-1:0]  insn_addr,
	input logic                   reg_write,
	input logic [`CORE_REG_W-1:0] reg_num,
	input logic                   jmp        // Redirect may replace a waiting address
);
	int fail_count = 0;  // Failed assertions so far

	// Memory stalled, address must hold unless a branch redirects
	addr_hold: assert property (@(posedge clk) disable iff (reset)
		insn_req && insn_wait |=> $stable(insn_addr) || jmp)
		else begin
			$error("insn_addr changed while the request waited");
			fail_count++;
		end

	// r15 is never a write target
	no_pc_write: assert property (@(posedge clk) disable iff (reset)
		reg_write |-> reg_num != `CORE_REG_W'(`CORE_NREGS - 1))
		else begin
			$error("register write to r15");
			fail_count++;
		end

	// Second reset cycle onward, outputs quiet
	reset_quiet: assert property (@(posedge clk)
		reset ##1 reset |-> !insn_req && !reg_write)
		else begin
			$error("request or write during reset");
			fail_count++;
		end
endmodule

bind core core_checker i_checker (
	.clk       (clk),
	.reset     (reset),
	.insn_req  (insn_req),
	.insn_wait (insn_wait),
	.insn_addr (insn_addr),
	.reg_write (reg_write),
	.reg_num   (reg_num),
	.jmp       (jmp)
);

// File: src/core.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core (
	input  logic                   clk,
	input  logic                   reset,
	output logic                   insn_req,
	output logic [`CORE_XLEN-1:0]  insn_addr,
	input  logic                   insn_wait,
	input  logic [`CORE_XLEN-1:0]  insn_data,
	output logic                   reg_write,
	output logic [`CORE_REG_W-1:0] reg_num,
	output logic [`CORE_XLEN-1:0]  reg_data,
	output logic [3:0]             flags
);
	logic                   stall;
	logic                   jmp;
	logic [`CORE_XLEN-1:0]  jmppc;
	logic                   f_valid;
	logic [`CORE_XLEN-1:0]  f_pc;
	logic [`CORE_XLEN-1:0]  f_insn;
	logic [`CORE_REG_W-1:0] rd_num_a;
	logic [`CORE_REG_W-1:0] rd_num_b;
	logic [`CORE_XLEN-1:0]  rd_pc;
	logic [`CORE_XLEN-1:0]  rd_data_a;
	logic [`CORE_XLEN-1:0]  rd_data_b;

	issue_if issue ();  // Decode to execute

	fetch i_fetch (
		.clk       (clk),
		.reset     (reset),
		.insn_wait (insn_wait),
		.insn_data (insn_data),
		.stall     (stall),
		.jmp       (jmp),
		.jmppc     (jmppc),
		.insn_req  (insn_req),
		.insn_addr (insn_addr),
		.f_valid   (f_valid),
		.f_pc      (f_pc),
		.f_insn    (f_insn)
	);

	regfile i_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_num_a  (rd_num_a),
		.rd_num_b  (rd_num_b),
		.rd_pc     (rd_pc),
		.wr_en     (reg_write),  // Retire port doubles as the write port
		.wr_num    (reg_num),
		.wr_data   (reg_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	decode i_decode (
		.clk       (clk),
		.reset     (reset),
		.f_valid   (f_valid),
		.f_pc      (f_pc),
		.f_insn    (f_insn),
		.jmp       (jmp),
		.flags_c   (flags[1]),
		.stall     (stall),
		.rd_num_a  (rd_num_a),
		.rd_num_b  (rd_num_b),
		.rd_pc     (rd_pc),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.issue     (issue.dec)
	);

	execute i_execute (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue.exe),
		.jmp       (jmp),
		.jmppc     (jmppc),
		.wr_en     (reg_write),
		.wr_num    (reg_num),
		.wr_data   (reg_data),
		.flags     (flags)
	);
endmodule

// File: src/execute.sv
`timescale 1ns/100ps
`include "core_config.svh"

module execute import core_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	issue_if.exe                   issue,
	output logic                   jmp,
	output logic [`CORE_XLEN-1:0]  jmppc,
	output logic                   wr_en,
	output logic [`CORE_REG_W-1:0] wr_num,
	output logic [`CORE_XLEN-1:0]  wr_data,
	output logic [3:0]             flags    // N, Z, C, V
);
	localparam logic [`CORE_REG_W-1:0] PC_REG = `CORE_REG_W'(`CORE_NREGS - 1);

	insn_t                 ins;
	logic                  pass;       // Condition holds
	logic                  known_op;
	logic                  is_dp;
	logic                  is_br;
	logic                  do_dp;
	logic [`CORE_XLEN-1:0] x;
	logic [`CORE_XLEN-1:0] y;
	logic                  cin;
	logic [`CORE_XLEN:0]   sum;        // Carry in the top bit
	logic [`CORE_XLEN-1:0] res;
	logic                  arith;
	logic [3:0]            nzcv;

	function automatic logic cond_ok(input logic [3:0] cond, input logic [3:0] f);
		logic n, z, c, v;
		n = f[3];
		z = f[2];
		c = f[1];
		v = f[0];
		case (cond)
			`CORE_COND_EQ: cond_ok = z;
			`CORE_COND_NE: cond_ok = !z;
			`CORE_COND_CS: cond_ok = c;
			`CORE_COND_CC: cond_ok = !c;
			`CORE_COND_MI: cond_ok = n;
			`CORE_COND_PL: cond_ok = !n;
			`CORE_COND_VS: cond_ok = v;
			`CORE_COND_VC: cond_ok = !v;
			`CORE_COND_HI: cond_ok = c && !z;
			`CORE_COND_LS: cond_ok = !c || z;
			`CORE_COND_GE: cond_ok = n == v;
			`CORE_COND_LT: cond_ok = n != v;
			`CORE_COND_GT: cond_ok = !z && n == v;
			`CORE_COND_LE: cond_ok = z || n != v;
			`CORE_COND_AL: cond_ok = 1'b1;
			default:       cond_ok = 1'b0;  // NV space
		endcase
	endfunction

	assign ins      = issue.insn;
	assign pass     = cond_ok(ins.dp.cond, flags);
	assign known_op = ins.dp.opcode inside {`CORE_OP_AND, `CORE_OP_EOR, `CORE_OP_SUB,
		`CORE_OP_RSB, `CORE_OP_ADD, `CORE_OP_CMP, `CORE_OP_ORR, `CORE_OP_MOV,
		`CORE_OP_BIC, `CORE_OP_MVN};
	assign is_dp    = ins.dp.fmt == 2'b00 && known_op &&
		(ins.dp.imm || ins.dp.operand[11:4] == 8'h00);  // No shifted rm
	assign is_br    = ins.br.fmt == 3'b101 && !ins.br.link;
	assign do_dp    = issue.valid && is_dp && pass;

	// One adder, SUB and CMP by default
	always_comb begin
		x   = issue.op_a;
		y   = ~issue.op_b;
		cin = 1'b1;
		case (ins.dp.opcode)
			`CORE_OP_ADD: begin
				y   = issue.op_b;
				cin = 1'b0;
			end
			`CORE_OP_RSB: begin
				x = issue.op_b;
				y = ~issue.op_a;
			end
			default: ;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {{`CORE_XLEN{1'b0}}, cin};

	always_comb begin
		arith = 1'b0;
		case (ins.dp.opcode)
			`CORE_OP_AND: res = issue.op_a & issue.op_b;
			`CORE_OP_EOR: res = issue.op_a ^ issue.op_b;
			`CORE_OP_ORR: res = issue.op_a | issue.op_b;
			`CORE_OP_MOV: res = issue.op_b;
			`CORE_OP_BIC: res = issue.op_a & ~issue.op_b;
			`CORE_OP_MVN: res = ~issue.op_b;
			default: begin
				res   = sum[`CORE_XLEN-1:0];  // ADD, SUB, RSB, CMP
				arith = 1'b1;
			end
		endcase
	end

	assign nzcv[3] = res[`CORE_XLEN-1];
	assign nzcv[2] = res == '0;
	assign nzcv[1] = arith ? sum[`CORE_XLEN] : issue.carry_in;  // Logical ops take shifter carry
	assign nzcv[0] = arith ? (x[`CORE_XLEN-1] == y[`CORE_XLEN-1] &&
		sum[`CORE_XLEN-1] != x[`CORE_XLEN-1]) : flags[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_en <= 1'b0;
			flags <= 4'h0;
		end else begin
			wr_en <= do_dp && ins.dp.opcode != `CORE_OP_CMP && ins.dp.rd != PC_REG;
			if (do_dp && ins.dp.s)
				flags <= nzcv;
		end
	end

	always_ff @(posedge clk) begin
		wr_num  <= ins.dp.rd;
		wr_data <= res;
	end

	// Target is pc+8 plus the word offset
	assign jmp   = issue.valid && is_br && pass;
	assign jmppc = issue.pc + `CORE_XLEN'd8 +
		{{(`CORE_XLEN - 26){ins.br.offset[23]}}, ins.br.offset, 2'b00};
endmodule

// File: src/decode.sv
`timescale 1ns/100ps
`include "core_config.svh"

module decode import core_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   f_valid,
	input  logic [`CORE_XLEN-1:0]  f_pc,
	input  logic [`CORE_XLEN-1:0]  f_insn,
	input  logic                   jmp,
	input  logic                   flags_c,     // C flag as execute holds it
	output logic                   stall,
	output logic [`CORE_REG_W-1:0] rd_num_a,
	output logic [`CORE_REG_W-1:0] rd_num_b,
	output logic [`CORE_XLEN-1:0]  rd_pc,
	input  logic [`CORE_XLEN-1:0]  rd_data_a,
	input  logic [`CORE_XLEN-1:0]  rd_data_b,
	issue_if.dec                   issue
);
	localparam logic [`CORE_REG_W-1:0] PC_REG = `CORE_REG_W'(`CORE_NREGS - 1);

	insn_t                 fi;         // Instruction being decoded
	logic [4:0]            rot_sh;     // Rotate amount, twice the field
	logic [`CORE_XLEN-1:0] imm32;
	logic [`CORE_XLEN-1:0] imm_val;
	logic [`CORE_XLEN-1:0] opnd_b;
	logic                  rot_imm;    // Immediate with a nonzero rotate
	logic                  carry;
	logic                  iss_dp;
	logic                  iss_wr;     // Older instruction will write rd
	logic                  raw_hz;
	logic                  c_hz;

	assign fi       = f_insn;
	assign rd_num_a = fi.dp.rn;
	assign rd_num_b = fi.dp.operand[3:0];  // rm
	assign rd_pc    = f_pc;

	// imm8 rotated right by 2*rot
	assign rot_sh  = {fi.dp.operand[11:8], 1'b0};
	assign imm32   = {{(`CORE_XLEN - 8){1'b0}}, fi.dp.operand[7:0]};
	assign imm_val = (imm32 >> rot_sh) | (imm32 << (6'(`CORE_XLEN) - {1'b0, rot_sh}));
	assign rot_imm = fi.dp.imm && rot_sh != 5'd0;
	assign opnd_b  = fi.dp.imm ? imm_val : rd_data_b;
	assign carry   = rot_imm ? imm_val[`CORE_XLEN-1] : flags_c;

	// Hazards against the instruction now in execute
	assign iss_dp = issue.valid && issue.insn.dp.fmt == 2'b00;
	assign iss_wr = iss_dp && issue.insn.dp.opcode != `CORE_OP_CMP &&
		issue.insn.dp.rd != PC_REG;
	assign raw_hz = iss_wr && (fi.dp.rn == issue.insn.dp.rd ||
		(!fi.dp.imm && fi.dp.operand[3:0] == issue.insn.dp.rd));
	assign c_hz   = iss_dp && issue.insn.dp.s && !rot_imm;  // flags_c not yet updated
	assign stall  = f_valid && fi.dp.fmt == 2'b00 && (raw_hz || c_hz);

	always_ff @(posedge clk) begin
		if (reset || jmp)
			issue.valid <= 1'b0;            // Flush younger work
		else
			issue.valid <= f_valid && !stall;  // Bubble while stalled
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			issue.pc       <= f_pc;
			issue.insn     <= fi;
			issue.op_a     <= rd_data_a;
			issue.op_b     <= opnd_b;
			issue.carry_in <= carry;
		end
	end
endmodule

// File: src/regfile.sv
`timescale 1ns/100ps
`include "core_config.svh"

module regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`CORE_REG_W-1:0] rd_num_a,
	input  logic [`CORE_REG_W-1:0] rd_num_b,
	input  logic [`CORE_XLEN-1:0]  rd_pc,     // Address of the reading instruction
	input  logic                   wr_en,
	input  logic [`CORE_REG_W-1:0] wr_num,
	input  logic [`CORE_XLEN-1:0]  wr_data,
	output logic [`CORE_XLEN-1:0]  rd_data_a,
	output logic [`CORE_XLEN-1:0]  rd_data_b
);
	localparam logic [`CORE_REG_W-1:0] PC_REG = `CORE_REG_W'(`CORE_NREGS - 1);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

	function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_W-1:0] num);
		if (num == PC_REG)
			read_port = rd_pc + `CORE_XLEN'd8;  // Pipeline view of r15
		else if (wr_en && wr_num == num)
			read_port = wr_data;                // Write-through
		else
			read_port = regs[num];
	endfunction

	always_comb begin
		rd_data_a = read_port(rd_num_a);
		rd_data_b = read_port(rd_num_b);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_num] <= wr_data;
		end
	end
endmodule

// File: src/fetch.sv
`timescale 1ns/100ps
`include "core_config.svh"

module fetch (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  insn_wait,
	input  logic [`CORE_XLEN-1:0] insn_data,
	input  logic                  stall,
	input  logic                  jmp,
	input  logic [`CORE_XLEN-1:0] jmppc,
	output logic                  insn_req,
	output logic [`CORE_XLEN-1:0] insn_addr,
	output logic                  f_valid,
	output logic [`CORE_XLEN-1:0] f_pc,
	output logic [`CORE_XLEN-1:0] f_insn
);
	logic                  running;     // Low for one cycle after reset
	logic [`CORE_XLEN-1:0] pc;          // Next address to request
	logic                  accept;
	logic                  pend;        // Data due on insn_data now
	logic [`CORE_XLEN-1:0] pend_pc;
	logic                  hold_valid;  // Data parked during a stall
	logic [`CORE_XLEN-1:0] hold_pc;
	logic [`CORE_XLEN-1:0] hold_insn;

	assign insn_req  = running & (!stall | jmp);
	assign insn_addr = jmp ? jmppc : pc;  // Redirect goes out at once
	assign accept    = insn_req & !insn_wait;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pc      <= `CORE_RESET_PC;
			pend    <= 1'b0;
		end else begin
			running <= 1'b1;
			pc      <= accept ? insn_addr + `CORE_XLEN'd4 : insn_addr;
			pend    <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pend_pc <= insn_addr;
	end

	// Park returning data while decode is stuck
	always_ff @(posedge clk) begin
		if (reset || jmp || !stall)
			hold_valid <= 1'b0;       // Consumed or flushed
		else if (pend)
			hold_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (stall && pend && !hold_valid) begin
			hold_pc   <= pend_pc;
			hold_insn <= insn_data;
		end
	end

	assign f_valid = (hold_valid | pend) & !jmp;  // Wrong path on a jump
	assign f_pc    = hold_valid ? hold_pc : pend_pc;
	assign f_insn  = hold_valid ? hold_insn : insn_data;
endmodule

// File: common/issue_if.sv
`timescale 1ns/100ps
`include "core_config.svh"

interface issue_if import core_pkg::*; ();
	logic                  valid;     // Slot holds a live instruction
	logic [`CORE_XLEN-1:0] pc;        // Address of the instruction
	insn_t                 insn;
	logic [`CORE_XLEN-1:0] op_a;      // rn value
	logic [`CORE_XLEN-1:0] op_b;      // Rotated immediate or rm value
	logic                  carry_in;  // Shifter carry out

	modport dec (output valid, pc, insn, op_a, op_b, carry_in);
	modport exe (input valid, pc, insn, op_a, op_b, carry_in);
endinterface

// File: common/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	// Data-processing layout
	typedef struct packed {
		logic [3:0]             cond;
		logic [1:0]             fmt;      // 2'b00 for data processing
		logic                   imm;      // Operand is a rotated immediate
		logic [3:0]             opcode;
		logic                   s;        // Update flags
		logic [`CORE_REG_W-1:0] rn;
		logic [`CORE_REG_W-1:0] rd;
		logic [11:0]            operand;  // rot:imm8, or shift:rm
	} dp_insn_t;

	// Branch layout
	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  fmt;                 // 3'b101 for B and BL
		logic        link;
		logic [23:0] offset;              // Signed word offset
	} br_insn_t;

	// Same word, read either way
	typedef union packed {
		dp_insn_t dp;
		br_insn_t br;
	} insn_t;

endpackage

// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN      32             // Data and address width
`define CORE_REG_W     4              // Register number width
`define CORE_NREGS     16
`define CORE_RESET_PC  32'h0000_0000  // First fetch address

// Data-processing opcodes, bits 24:21
`define CORE_OP_AND    4'h0
`define CORE_OP_EOR    4'h1
`define CORE_OP_SUB    4'h2
`define CORE_OP_RSB    4'h3
`define CORE_OP_ADD    4'h4
`define CORE_OP_CMP    4'ha
`define CORE_OP_ORR    4'hc
`define CORE_OP_MOV    4'hd
`define CORE_OP_BIC    4'he
`define CORE_OP_MVN    4'hf

// Condition field, bits 31:28
`define CORE_COND_EQ   4'h0
`define CORE_COND_NE   4'h1
`define CORE_COND_CS   4'h2
`define CORE_COND_CC   4'h3
`define CORE_COND_MI   4'h4
`define CORE_COND_PL   4'h5
`define CORE_COND_VS   4'h6
`define CORE_COND_VC   4'h7
`define CORE_COND_HI   4'h8
`define CORE_COND_LS   4'h9
`define CORE_COND_GE   4'ha
`define CORE_COND_LT   4'hb
`define CORE_COND_GT   4'hc
`define CORE_COND_LE   4'hd
`define CORE_COND_AL   4'he

`endif
